// File: src/board_pkg.sv
`default_nettype none

package board_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_W  = 4;
    localparam int OP_W    = 3;
    localparam int NUM_OPS = 8;    // also one-hot width
    localparam int CNT_MOD = 100;
    localparam int CNT_W   = $clog2(CNT_MOD);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_NOT  = 3'd5,   // ~a
        OP_SLT  = 3'd6,   // signed a < b
        OP_PENC = 3'd7    // priority encode of the 8 data bits
    } opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command word, two readings of the same 11 bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        opcode_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } alu_view_t;

    typedef struct packed {
        opcode_e             op;
        logic [2*DATA_W-1:0] vec;   // bit 7 is msb
    } penc_view_t;

    typedef union packed {
        alu_view_t  alu;
        penc_view_t penc;
    } cmd_word_u;

    // active low, {dp,g,f,e,d,c,b,a}, dp kept dark
    localparam logic [7:0] SEG_PATTERNS [0:9] = '{
        8'hC0,   // 0
        8'hF9,   // 1
        8'hA4,   // 2
        8'hB0,   // 3
        8'h99,   // 4
        8'h92,   // 5
        8'h82,   // 6
        8'hF8,   // 7
        8'h80,   // 8
        8'h90    // 9
    };

endpackage

`default_nettype wire

// File: src/stage_if.sv
`timescale 1ns/1ns
`default_nettype none

// decoded command, decode -> execute
interface stage_if;

    logic                             valid;   // one cycle per command
    logic [board_pkg::NUM_OPS-1:0]    onehot;
    logic [board_pkg::DATA_W-1:0]     op_a;
    logic [board_pkg::DATA_W-1:0]     op_b;
    logic [2*board_pkg::DATA_W-1:0]   vec;

    modport src (
        output valid,
        output onehot,
        output op_a,
        output op_b,
        output vec
    );

    modport dst (
        input  valid,
        input  onehot,
        input  op_a,
        input  op_b,
        input  vec
    );

endinterface

`default_nettype wire

// File: src/cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    input  board_pkg::cmd_word_u cmd_word,
    stage_if.src                 dec
);

    logic [board_pkg::NUM_OPS-1:0] onehot_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 3-to-8 expansion of the opcode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < board_pkg::NUM_OPS; i++) begin
            onehot_nxt[i] = (cmd_word.alu.op == board_pkg::opcode_e'(i));
        end
    end

    // strobe to execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= cmd_valid;
        end
    end

    // payload loads on every strobe
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            dec.onehot <= onehot_nxt;
            dec.op_a   <= cmd_word.alu.a;     // alu reading
            dec.op_b   <= cmd_word.alu.b;
            dec.vec    <= cmd_word.penc.vec;  // encoder reading of the same bits
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // execute picks the operation from the one-hot alone
    a_onehot_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        dec.valid |-> $onehot(dec.onehot)
    ) else $error("decoder one-hot not one-hot while valid");

endmodule

`default_nettype wire

// File: src/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
    input  logic                          clk,
    input  logic                          rst_n,
    stage_if.dst                          dec,
    output logic                          res_valid,
    output logic [board_pkg::DATA_W-1:0]  res,
    output logic                          zero,
    output logic                          carry,
    output logic                          overflow,
    output logic                          penc_none
);

    logic                         sub;
    logic [board_pkg::DATA_W-1:0] b_eff;
    logic [board_pkg::DATA_W:0]   sum;      // msb is carry out of bit 3
    logic [2:0]                   penc_idx;
    logic [board_pkg::DATA_W-1:0] res_nxt;
    logic                         carry_nxt;
    logic                         ovf_nxt;
    logic                         none_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sub   = dec.onehot[board_pkg::OP_SUB];
    assign b_eff = sub ? ~dec.op_b : dec.op_b;   // a - b = a + ~b + 1
    assign sum   = {1'b0, dec.op_a} + {1'b0, b_eff} + {{board_pkg::DATA_W{1'b0}}, sub};

    // 8-to-3 priority encoder, highest set bit wins
    always_comb begin
        penc_idx = 3'd0;
        for (int i = 0; i < 2 * board_pkg::DATA_W; i++) begin
            if (dec.vec[i]) begin
                penc_idx = 3'(i);
            end
        end
    end

    always_comb begin
        res_nxt   = '0;
        carry_nxt = 1'b0;
        ovf_nxt   = 1'b0;
        none_nxt  = 1'b0;
        case (1'b1)
            dec.onehot[board_pkg::OP_ADD],
            dec.onehot[board_pkg::OP_SUB]: begin
                res_nxt   = sum[board_pkg::DATA_W-1:0];
                carry_nxt = sum[board_pkg::DATA_W];
                // same sign in, other sign out
                ovf_nxt   = (dec.op_a[3] == b_eff[3]) && (sum[3] != dec.op_a[3]);
            end
            dec.onehot[board_pkg::OP_AND]:  res_nxt = dec.op_a & dec.op_b;
            dec.onehot[board_pkg::OP_OR]:   res_nxt = dec.op_a | dec.op_b;
            dec.onehot[board_pkg::OP_XOR]:  res_nxt = dec.op_a ^ dec.op_b;
            dec.onehot[board_pkg::OP_NOT]:  res_nxt = ~dec.op_a;
            dec.onehot[board_pkg::OP_SLT]: begin
                res_nxt = {3'b000, ($signed(dec.op_a) < $signed(dec.op_b))};
            end
            dec.onehot[board_pkg::OP_PENC]: begin
                res_nxt  = {1'b0, penc_idx};
                none_nxt = (dec.vec == '0);
            end
            default: res_nxt = '0;
        endcase
    end

    // outputs hold until the next command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
            zero      <= 1'b0;
            carry     <= 1'b0;
            overflow  <= 1'b0;
            penc_none <= 1'b0;
        end else begin
            res_valid <= dec.valid;
            if (dec.valid) begin
                res       <= res_nxt;
                zero      <= (res_nxt == '0);
                carry     <= carry_nxt;
                overflow  <= ovf_nxt;
                penc_none <= none_nxt;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_one_result_per_cmd : assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid == $past(dec.valid)
    ) else $error("res_valid out of step with decode valid");

    // only add and sub may raise the arithmetic flags
    a_logic_no_flags : assert property (
        @(posedge clk) disable iff (!rst_n)
        dec.valid && !(dec.onehot[board_pkg::OP_ADD] || sub) |=> !carry && !overflow
    ) else $error("carry or overflow set by a non-arithmetic opcode");

endmodule

`default_nettype wire

// File: src/result_display.sv
`timescale 1ns/1ns
`default_nettype none

module result_display (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         res_valid,
    input  logic [board_pkg::DATA_W-1:0] res,
    output logic [7:0]                   seg0,
    output logic [7:0]                   seg1,
    output logic [7:0]                   seg2,
    output logic [7:0]                   seg3
);

    logic [board_pkg::CNT_W-1:0] cnt;
    logic [board_pkg::CNT_W-1:0] cnt_nxt;
    logic [3:0]                  res_ones;
    logic [3:0]                  res_tens;
    logic [3:0]                  cnt_ones;
    logic [3:0]                  cnt_tens;

    // digit to segment pattern, blank for anything past 9
    function automatic logic [7:0] seg_of(input logic [3:0] digit);
        logic [7:0] pat;
        pat = 8'hFF;
        if (digit <= 4'd9) begin
            pat = board_pkg::SEG_PATTERNS[digit];
        end
        return pat;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command counter, mod 100
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (cnt == board_pkg::CNT_W'(board_pkg::CNT_MOD - 1)) begin
            cnt_nxt = '0;    // 99 -> 0
        end else begin
            cnt_nxt = cnt + 1'b1;
        end
    end

    // decimal split
    assign res_ones = 4'(res % 4'd10);
    assign res_tens = 4'(res / 4'd10);
    assign cnt_ones = 4'(cnt_nxt % 7'd10);
    assign cnt_tens = 4'(cnt_nxt / 7'd10);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (res_valid) begin
            cnt <= cnt_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // segment drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg0 <= board_pkg::SEG_PATTERNS[0];
            seg1 <= board_pkg::SEG_PATTERNS[0];
            seg2 <= board_pkg::SEG_PATTERNS[0];
            seg3 <= board_pkg::SEG_PATTERNS[0];
        end else if (res_valid) begin
            seg0 <= seg_of(res_ones);   // latest result
            seg1 <= seg_of(res_tens);
            seg2 <= seg_of(cnt_ones);   // count incl. this command
            seg3 <= seg_of(cnt_tens);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_cnt_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt < board_pkg::CNT_W'(board_pkg::CNT_MOD)
    ) else $error("command counter reached %0d", cnt);

endmodule

`default_nettype wire

// File: src/board_top.sv
`timescale 1ns/1ns
`default_nettype none

module board_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_valid,
    input  board_pkg::cmd_word_u         cmd_word,
    output logic                         res_valid,
    output logic [board_pkg::DATA_W-1:0] alu_res,
    output logic                         alu_zero,
    output logic                         alu_carry,
    output logic                         alu_overflow,
    output logic                         penc_none,
    output logic [7:0]                   seg0,
    output logic [7:0]                   seg1,
    output logic [7:0]                   seg2,
    output logic [7:0]                   seg3
);

    // decode -> execute
    stage_if u_stage ();

    cmd_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word),
        .dec       (u_stage.src)
    );

    alu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (u_stage.dst),
        .res_valid (res_valid),
        .res       (alu_res),
        .zero      (alu_zero),
        .carry     (alu_carry),
        .overflow  (alu_overflow),
        .penc_none (penc_none)
    );

    // result digits and command count
    result_display u_display (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res       (alu_res),
        .seg0      (seg0),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3)
    );

endmodule

`default_nettype wire

// File: dv/board_tb.sv
`timescale 1ns/1ns
`default_nettype none

module board_tb;

    typedef struct packed {
        logic [3:0] res;
        logic       zero;
        logic       carry;
        logic       ovf;
        logic       none;
    } exp_t;

    typedef struct packed {
        logic [10:0] word;
        exp_t        exp;
    } vec_t;

    localparam int NUM_VEC      = 27;
    localparam int NUM_RAND     = 150;
    localparam int NUM_CMD      = NUM_VEC + NUM_RAND;
    localparam int WATCHDOG_CYC = 20 * NUM_CMD + 100;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed vectors: word, then {res, zero, carry, ovf, none}
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam vec_t VECTORS [NUM_VEC] = '{
        '{{board_pkg::OP_ADD, 4'd7, 4'd1},     '{4'd8,  1'b0, 1'b0, 1'b1, 1'b0}},  // 7+1
        '{{board_pkg::OP_ADD, 4'd15, 4'd1},    '{4'd0,  1'b1, 1'b1, 1'b0, 1'b0}},  // 15+1
        '{{board_pkg::OP_ADD, 4'd3, 4'd4},     '{4'd7,  1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_ADD, 4'd8, 4'd8},     '{4'd0,  1'b1, 1'b1, 1'b1, 1'b0}},
        '{{board_pkg::OP_SUB, 4'd8, 4'd1},     '{4'd7,  1'b0, 1'b1, 1'b1, 1'b0}},  // 8-1
        '{{board_pkg::OP_SUB, 4'd0, 4'd1},     '{4'd15, 1'b0, 1'b0, 1'b0, 1'b0}},  // 0-1
        '{{board_pkg::OP_SUB, 4'd5, 4'd5},     '{4'd0,  1'b1, 1'b1, 1'b0, 1'b0}},
        '{{board_pkg::OP_SUB, 4'd6, 4'd2},     '{4'd4,  1'b0, 1'b1, 1'b0, 1'b0}},
        '{{board_pkg::OP_AND, 4'hC, 4'hA},     '{4'd8,  1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_AND, 4'h5, 4'hA},     '{4'd0,  1'b1, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_OR, 4'hC, 4'h3},      '{4'd15, 1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_OR, 4'h0, 4'h0},      '{4'd0,  1'b1, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_XOR, 4'hF, 4'h5},     '{4'd10, 1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_XOR, 4'h9, 4'h9},     '{4'd0,  1'b1, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_NOT, 4'h6, 4'h3},     '{4'd9,  1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_NOT, 4'hF, 4'h0},     '{4'd0,  1'b1, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_SLT, 4'hF, 4'h1},     '{4'd1,  1'b0, 1'b0, 1'b0, 1'b0}},  // -1 < 1
        '{{board_pkg::OP_SLT, 4'h3, 4'hE},     '{4'd0,  1'b1, 1'b0, 1'b0, 1'b0}},  // 3 < -2
        '{{board_pkg::OP_SLT, 4'h5, 4'h5},     '{4'd0,  1'b1, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_SLT, 4'h8, 4'h7},     '{4'd1,  1'b0, 1'b0, 1'b0, 1'b0}},  // -8 < 7
        '{{board_pkg::OP_PENC, 8'b0000_0001},  '{4'd0,  1'b1, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_PENC, 8'b1000_0000},  '{4'd7,  1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_PENC, 8'b0001_0000},  '{4'd4,  1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_PENC, 8'b0101_1010},  '{4'd6,  1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_PENC, 8'b0010_0110},  '{4'd5,  1'b0, 1'b0, 1'b0, 1'b0}},
        '{{board_pkg::OP_PENC, 8'b0000_0000},  '{4'd0,  1'b1, 1'b0, 1'b0, 1'b1}},  // none
        '{{board_pkg::OP_PENC, 8'b1111_1111},  '{4'd7,  1'b0, 1'b0, 1'b0, 1'b0}}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cmd_valid;
    logic [10:0] cmd_word;
    logic        res_valid;
    logic [3:0]  alu_res;
    logic        alu_zero;
    logic        alu_carry;
    logic        alu_overflow;
    logic        penc_none;
    logic [7:0]  seg0;
    logic [7:0]  seg1;
    logic [7:0]  seg2;
    logic [7:0]  seg3;

    int          cyc = 0;
    int          mismatch_errs = 0;
    int          other_errs = 0;
    int          cmd_count = 0;
    exp_t        exp_q [$];
    int          due_q [$];
    exp_t        head;
    int          head_due;
    logic        seg_pending = 1'b0;
    logic [7:0]  exp_seg0;
    logic [7:0]  exp_seg1;
    logic [7:0]  exp_seg2;
    logic [7:0]  exp_seg3;
    logic [31:0] lfsr_state = 32'h4a6aa3e9;
    logic [31:0] rnd;

    board_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_word     (cmd_word),
        .res_valid    (res_valid),
        .alu_res      (alu_res),
        .alu_zero     (alu_zero),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow),
        .penc_none    (penc_none),
        .seg0         (seg0),
        .seg1         (seg1),
        .seg2         (seg2),
        .seg3         (seg3)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic exp_t model(input logic [10:0] word);
        exp_t       e;
        logic [3:0] a;
        logic [3:0] b;
        logic [4:0] sum;
        logic       found;
        e     = '0;
        a     = word[7:4];
        b     = word[3:0];
        found = 1'b0;
        case (word[10:8])
            3'd0: begin
                sum     = {1'b0, a} + {1'b0, b};
                e.res   = sum[3:0];
                e.carry = sum[4];
                e.ovf   = (a[3] == b[3]) && (sum[3] != a[3]);
            end
            3'd1: begin
                sum     = {1'b0, a} + {1'b0, ~b} + 5'd1;
                e.res   = sum[3:0];
                e.carry = sum[4];
                e.ovf   = (a[3] != b[3]) && (sum[3] != a[3]);   // b sign flipped
            end
            3'd2: e.res = a & b;
            3'd3: e.res = a | b;
            3'd4: e.res = a ^ b;
            3'd5: e.res = ~a;
            3'd6: e.res = ($signed(a) < $signed(b)) ? 4'd1 : 4'd0;
            default: begin
                for (int i = 7; i >= 0; i--) begin
                    if (!found && word[i]) begin
                        e.res = 4'(i);
                        found = 1'b1;
                    end
                end
                e.none = !found;
            end
        endcase
        e.zero = (e.res == 4'd0);
        return e;
    endfunction

    // active low, dp dark
    function automatic logic [7:0] seg_pattern(input int digit);
        case (digit)
            0: return 8'hC0;
            1: return 8'hF9;
            2: return 8'hA4;
            3: return 8'hB0;
            4: return 8'h99;
            5: return 8'h92;
            6: return 8'h82;
            7: return 8'hF8;
            8: return 8'h80;
            9: return 8'h90;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_val(input string name, input int exp, input int got);
        if (exp != got) begin
            mismatch_errs++;
            $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    task automatic send_cmd(input logic [10:0] word, input exp_t exp);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_word  = word;
        exp_q.push_back(exp);
        due_q.push_back(cyc + 2);   // res_valid two cycles on
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor, samples on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (seg_pending) begin
            check_val("seg0", exp_seg0, seg0);
            check_val("seg1", exp_seg1, seg1);
            check_val("seg2", exp_seg2, seg2);
            check_val("seg3", exp_seg3, seg3);
            seg_pending = 1'b0;
        end
        if (rst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("error at %0t ns: res_valid with no command outstanding", $time);
            end else begin
                head     = exp_q.pop_front();
                head_due = due_q.pop_front();
                if (head_due != cyc) begin
                    other_errs++;
                    $display("error at %0t ns: res_valid in cycle %0d, due in cycle %0d",
                             $time, cyc, head_due);
                end
                check_val("alu_res", head.res, alu_res);
                check_val("alu_zero", head.zero, alu_zero);
                check_val("alu_carry", head.carry, alu_carry);
                check_val("alu_overflow", head.ovf, alu_overflow);
                check_val("penc_none", head.none, penc_none);
                cmd_count   = (cmd_count + 1) % 100;
                exp_seg0    = seg_pattern(head.res % 10);
                exp_seg1    = seg_pattern(head.res / 10);
                exp_seg2    = seg_pattern(cmd_count % 10);
                exp_seg3    = seg_pattern(cmd_count / 10);
                seg_pending = 1'b1;   // digits land one cycle later
            end
        end else if (rst_n && due_q.size() != 0 && due_q[0] <= cyc) begin
            other_errs++;
            $display("error at %0t ns: no res_valid for the command due in cycle %0d",
                     $time, due_q[0]);
            head     = exp_q.pop_front();
            head_due = due_q.pop_front();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_word  = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // idle outputs after reset
        check_val("res_valid", 0, res_valid);
        check_val("alu_res", 0, alu_res);
        check_val("alu_zero", 0, alu_zero);
        check_val("alu_carry", 0, alu_carry);
        check_val("alu_overflow", 0, alu_overflow);
        check_val("penc_none", 0, penc_none);
        check_val("seg0", seg_pattern(0), seg0);
        check_val("seg1", seg_pattern(0), seg1);
        check_val("seg2", seg_pattern(0), seg2);
        check_val("seg3", seg_pattern(0), seg3);

        for (int n = 0; n < NUM_VEC; n++) begin
            if (model(VECTORS[n].word) != VECTORS[n].exp) begin
                other_errs++;
                $display("error: reference model disagrees with vector %0d", n);
            end
            send_cmd(VECTORS[n].word, VECTORS[n].exp);   // back to back
        end
        idle_cycle();

        for (int n = 0; n < NUM_RAND; n++) begin
            draw_bits(2, rnd);
            if (rnd[1:0] == 2'b11) begin
                idle_cycle();
            end
            draw_bits(11, rnd);
            send_cmd(rnd[10:0], model(rnd[10:0]));
        end
        idle_cycle();

        while (due_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);

        $display("done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYC * 20);
        $display("timeout: run did not finish in %0d cycles, %0d mismatches, %0d other errors",
                 WATCHDOG_CYC, mismatch_errs, other_errs);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/board_pkg.sv
src/stage_if.sv
src/cmd_decoder.sv
src/alu_execute.sv
src/result_display.sv
src/board_top.sv
dv/board_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module board_tb \
    -f src.f --Mdir obj_dir -o board_sim > build.log 2>&1 \
    && ./obj_dir/board_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^=== PASS ===$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
